// ==== Makefile ====
TOP := ecc_rmw_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): build.f $(wildcard design/*.sv design/*.svh verif/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f build.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/100ps \
		-f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+design
design/ecc_pkg.sv
design/ecc_rmw_ctrl.sv
design/ecc_decode.sv
design/ecc_merge.sv
design/ecc_encode.sv
design/ecc_rmw_top.sv
verif/tb_clkgen.sv
verif/ecc_rmw_properties.sv
verif/ecc_rmw_tb.sv

// ==== design/ecc_consts.svh ====
`ifndef ECC_CONSTS_SVH
`define ECC_CONSTS_SVH

// data word and stored codeword
`define ECC_DATA_W 32
`define ECC_CW_W 38

// parity bits sit at 1-based positions 1, 2, 4, 8, 16, 32
`define ECC_PAR_W 6

// request fields
`define ECC_ADDR_W 32
`define ECC_STRB_W (`ECC_DATA_W / 8)

// cycles from the read strobe to valid douta
`define ECC_RD_WAIT 3

`endif

// ==== design/ecc_decode.sv ====
`include "ecc_consts.svh"

module ecc_decode
  import ecc_pkg::*;
(
  input  logic e_clk,
  input  logic e_rst,
  input  logic dec_ld,
  input  cw_t  douta,
  output dec_t dec
);

  data_t old_data;
  syn_t  syn;

  // data bits fill the non-power-of-two positions in order
  always_comb
  begin
    int j;
    j = 0;
    old_data = '0;
    for (int p = 1; p <= `ECC_CW_W; p++)
    begin
      if ((p & (p - 1)) != 0)
      begin
        old_data[j] = douta[p-1];
        j++;
      end
    end
  end

  // syndrome bit k checks every position with index bit k set
  always_comb
  begin
    syn = '0;
    for (int k = 0; k < `ECC_PAR_W; k++)
    begin
      for (int p = 1; p <= `ECC_CW_W; p++)
      begin
        if (p[k])
          syn[k] = syn[k] ^ douta[p-1];
      end
    end
  end

  // detect only, the old word goes on uncorrected
  always_ff @(posedge e_clk)
  begin
    if (e_rst)
      dec <= '0;
    else if (dec_ld)
    begin
      dec.data <= old_data;
      dec.syn  <= syn;
      dec.err  <= |syn;
    end
  end

endmodule

// ==== design/ecc_encode.sv ====
`include "ecc_consts.svh"

module ecc_encode
  import ecc_pkg::*;
(
  input  logic  e_clk,
  input  logic  e_rst,
  input  logic  enc_ld,
  input  data_t data,
  output cw_t   cw
);

  cw_t  placed;
  syn_t par;
  cw_t  cw_d;

  // data into the non-power-of-two slots, parity slots left at zero
  always_comb
  begin
    int j;
    j = 0;
    placed = '0;
    for (int p = 1; p <= `ECC_CW_W; p++)
    begin
      if ((p & (p - 1)) != 0)
      begin
        placed[p-1] = data[j];
        j++;
      end
    end
  end

  // even parity over the positions each check bit covers
  always_comb
  begin
    par = '0;
    for (int k = 0; k < `ECC_PAR_W; k++)
    begin
      for (int p = 1; p <= `ECC_CW_W; p++)
      begin
        if (p[k])
          par[k] = par[k] ^ placed[p-1];
      end
    end
  end

  always_comb
  begin
    cw_d = placed;
    for (int k = 0; k < `ECC_PAR_W; k++)
    begin
      cw_d[(1 << k) - 1] = par[k];
    end
  end

  always_ff @(posedge e_clk)
  begin
    if (e_rst)
      cw <= '0;
    else if (enc_ld)
      cw <= cw_d;
  end

endmodule

// ==== design/ecc_merge.sv ====
`include "ecc_consts.svh"

module ecc_merge
  import ecc_pkg::*;
(
  input  logic  e_clk,
  input  logic  e_rst,
  input  logic  mrg_ld,
  input  data_t old_data,
  input  data_t new_data,
  input  strb_t strb,
  output data_t merged
);

  data_t merged_d;

  // strobe bit set takes the new byte
  always_comb
  begin
    for (int b = 0; b < `ECC_STRB_W; b++)
    begin
      merged_d[b*8 +: 8] = strb[b] ? new_data[b*8 +: 8] : old_data[b*8 +: 8];
    end
  end

  always_ff @(posedge e_clk)
  begin
    if (e_rst)
      merged <= '0;
    else if (mrg_ld)
      merged <= merged_d;
  end

endmodule

// ==== design/ecc_pkg.sv ====
`include "ecc_consts.svh"

package ecc_pkg;

  typedef logic [`ECC_DATA_W-1:0] data_t;
  typedef logic [`ECC_CW_W-1:0]   cw_t;
  typedef logic [`ECC_STRB_W-1:0] strb_t;
  typedef logic [`ECC_ADDR_W-1:0] addr_t;
  typedef logic [`ECC_PAR_W-1:0]  syn_t;

  // write request as seen at the ports
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } wr_cmd_t;

  // old word pulled from the codeword, with its check result
  typedef struct packed {
    data_t data;
    syn_t  syn;
    logic  err;
  } dec_t;

  // single memory port, shared by read and write
  typedef struct packed {
    logic  ena;
    logic  wea;
    addr_t addr;
    cw_t   wdata;
  } mem_req_t;

endpackage

// ==== design/ecc_rmw_ctrl.sv ====
`include "ecc_consts.svh"

module ecc_rmw_ctrl
  import ecc_pkg::*;
(
  input  logic    e_clk,
  input  logic    e_rst,
  input  logic    wr_req,
  input  wr_cmd_t cmd,
  input  logic    mem_full,
  output logic    en_ready,
  output logic    rd_stb,
  output logic    dec_ld,
  output logic    mrg_ld,
  output logic    enc_ld,
  output wr_cmd_t cmd_q,
  output logic    mem_ctl_ena,
  output logic    mem_ctl_wea,
  output logic    bvalid
);

  localparam int WAIT_W = $clog2(`ECC_RD_WAIT + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,
    ST_WAIT,
    ST_DECODE,
    ST_MERGE,
    ST_ENCODE,
    ST_WRITE
  } state_t;

  state_t            state;
  state_t            state_nxt;
  logic [WAIT_W-1:0] wait_cnt;
  logic              idle_q;
  logic              accept;

  // idle_q stays low through reset, so ready does too
  assign en_ready = idle_q & ~mem_full;
  assign accept   = wr_req & en_ready;

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
        if (accept)
          state_nxt = ST_READ;
      ST_READ:
        state_nxt = ST_WAIT;
      ST_WAIT:
        // read cycle counts as the first wait cycle
        if (wait_cnt == WAIT_W'(`ECC_RD_WAIT - 1))
          state_nxt = ST_DECODE;
      ST_DECODE:
        state_nxt = ST_MERGE;
      ST_MERGE:
        state_nxt = ST_ENCODE;
      ST_ENCODE:
        state_nxt = ST_WRITE;
      default:
        state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge e_clk)
  begin
    if (e_rst)
    begin
      state    <= ST_IDLE;
      idle_q   <= 1'b0;
      wait_cnt <= '0;
    end
    else
    begin
      state  <= state_nxt;
      idle_q <= (state_nxt == ST_IDLE);
      if (state == ST_READ)
        wait_cnt <= WAIT_W'(1);
      else if (state == ST_WAIT)
        wait_cnt <= wait_cnt + WAIT_W'(1);
    end
  end

  // request held for the whole operation
  always_ff @(posedge e_clk)
  begin
    if (accept)
      cmd_q <= cmd;
  end

  assign rd_stb      = (state == ST_READ);
  assign dec_ld      = (state == ST_DECODE);
  assign mrg_ld      = (state == ST_MERGE);
  assign enc_ld      = (state == ST_ENCODE);
  assign mem_ctl_wea = (state == ST_WRITE);
  assign mem_ctl_ena = rd_stb | mem_ctl_wea;
  assign bvalid      = mem_ctl_wea;

endmodule

// ==== design/ecc_rmw_top.sv ====
module ecc_rmw_top
  import ecc_pkg::*;
(
  input  logic     e_clk,
  input  logic     e_rst,
  input  logic     wr_req,
  input  wr_cmd_t  cmd,
  input  logic     mem_full,
  input  cw_t      douta,
  output logic     en_ready,
  output mem_req_t mem,
  output logic     bvalid,
  output logic     err_detected
);

  logic    dec_ld;
  logic    mrg_ld;
  logic    enc_ld;
  logic    mem_ctl_ena;
  logic    mem_ctl_wea;
  wr_cmd_t cmd_q;
  dec_t    dec;
  data_t   merged;
  cw_t     cw;

  ecc_rmw_ctrl u_ctrl (
    .e_clk       (e_clk),
    .e_rst       (e_rst),
    .wr_req      (wr_req),
    .cmd         (cmd),
    .mem_full    (mem_full),
    .en_ready    (en_ready),
    // read enable is already part of mem_ctl_ena
    .rd_stb      (),
    .dec_ld      (dec_ld),
    .mrg_ld      (mrg_ld),
    .enc_ld      (enc_ld),
    .cmd_q       (cmd_q),
    .mem_ctl_ena (mem_ctl_ena),
    .mem_ctl_wea (mem_ctl_wea),
    .bvalid      (bvalid)
  );

  ecc_decode u_decode (
    .e_clk  (e_clk),
    .e_rst  (e_rst),
    .dec_ld (dec_ld),
    .douta  (douta),
    .dec    (dec)
  );

  ecc_merge u_merge (
    .e_clk    (e_clk),
    .e_rst    (e_rst),
    .mrg_ld   (mrg_ld),
    .old_data (dec.data),
    .new_data (cmd_q.data),
    .strb     (cmd_q.strb),
    .merged   (merged)
  );

  ecc_encode u_encode (
    .e_clk  (e_clk),
    .e_rst  (e_rst),
    .enc_ld (enc_ld),
    .data   (merged),
    .cw     (cw)
  );

  // same latched address for the read and the write back
  assign mem = '{ena: mem_ctl_ena, wea: mem_ctl_wea, addr: cmd_q.addr, wdata: cw};

  assign err_detected = dec.err;

endmodule

// ==== verif/ecc_rmw_properties.sv ====
module ecc_rmw_properties
  import ecc_pkg::*;
(
  input logic     e_clk,
  input logic     e_rst,
  input logic     en_ready,
  input mem_req_t mem,
  input logic     bvalid
);
  timeunit 1ns;
  timeprecision 100ps;

  // no write without the port enabled
  wea_needs_ena: assert property (
    @(posedge e_clk) disable iff (e_rst) mem.wea |-> mem.ena
  ) else $error("memory write enable high while port enable is low");

  // response pulse marks the write cycle
  bvalid_is_write: assert property (
    @(posedge e_clk) disable iff (e_rst) bvalid == mem.wea
  ) else $error("write response does not match memory write enable");

  // ready only in idle, port busy only outside idle
  ready_not_busy: assert property (
    @(posedge e_clk) disable iff (e_rst) !(en_ready && mem.ena)
  ) else $error("ready is high while the memory port is in use");

endmodule

// ==== verif/ecc_rmw_tb.sv ====
`include "ecc_consts.svh"

module ecc_rmw_tb
  import ecc_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NROWS       = 10;
  localparam int TIMEOUT_CYC = NROWS * 20 + 50;
  localparam int RD_LAT      = 1;
  localparam int WR_LAT      = RD_LAT + `ECC_RD_WAIT + 3;
  localparam int RAND_SEED   = 34296;

  logic     e_clk;
  logic     e_rst;
  logic     wr_req;
  wr_cmd_t  cmd;
  logic     mem_full;
  cw_t      douta;
  logic     en_ready;
  mem_req_t mem;
  logic     bvalid;
  logic     err_detected;
  int       cyc = 0;

  string row_name [NROWS];
  addr_t row_addr [NROWS];
  data_t row_data [NROWS];
  strb_t row_strb [NROWS];
  data_t row_old  [NROWS];
  int    row_flip [NROWS];
  int    row_hold [NROWS];

  tb_clkgen u_clkgen (.e_clk(e_clk), .e_rst(e_rst));

  ecc_rmw_top u_dut (.*);

  bind ecc_rmw_top ecc_rmw_properties u_props (.e_clk(e_clk), .e_rst(e_rst),
    .en_ready(en_ready), .mem(mem), .bvalid(bvalid));

  always @(posedge e_clk)
  begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Test FAILED");
      $fatal(1);
    end
  end

  // parity vector is the xor of the positions holding a one
  function automatic cw_t ref_encode(input data_t d);
    cw_t        c;
    logic [5:0] s;
    int         j;
    c = '0;
    s = '0;
    j = 0;
    for (int p = 1; p <= `ECC_CW_W; p++)
    begin
      if ($countones(p) != 1)
      begin
        c[p-1] = d[j];
        if (d[j])
          s = s ^ 6'(p);
        j++;
      end
    end
    for (int k = 0; k < `ECC_PAR_W; k++)
      c[(1 << k) - 1] = s[k];
    return c;
  endfunction

  function automatic data_t ref_extract(input cw_t c);
    data_t d;
    int    j;
    d = '0;
    j = 0;
    for (int p = 1; p <= `ECC_CW_W; p++)
    begin
      if ($countones(p) != 1)
      begin
        d[j] = c[p-1];
        j++;
      end
    end
    return d;
  endfunction

  function automatic data_t ref_merge(input data_t nw, input data_t od, input strb_t s);
    data_t mask;
    mask = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    return (nw & mask) | (od & ~mask);
  endfunction

  task automatic check_val(input string nm, input string what,
                           input logic [63:0] exp_v, input logic [63:0] act_v);
    if (act_v !== exp_v)
    begin
      $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h", nm, what, exp_v, act_v);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic set_row(input int i, input string nm, input addr_t a, input data_t d,
                         input strb_t s, input data_t od, input int flip, input int hold);
    row_name[i] = nm;
    row_addr[i] = a;
    row_data[i] = d;
    row_strb[i] = s;
    row_old[i]  = od;
    row_flip[i] = flip;
    row_hold[i] = hold;
  endtask

  // name, addr, new data, strobe, old data, flipped codeword bit, mem_full cycles
  task automatic load_table();
    int unsigned r [6];
    set_row(0, "full_strobe", 32'h0000_1000, 32'hDEAD_BEEF, 4'hF, 32'h1234_5678, -1, 0);
    set_row(1, "low_half", 32'h0000_2004, 32'hAABB_CCDD, 4'h3, 32'h1122_3344, -1, 0);
    set_row(2, "mixed_strobe", 32'h8000_0010, 32'hCAFE_F00D, 4'h5, 32'h0F0F_0F0F, -1, 0);
    set_row(3, "zero_strobe", 32'h0000_0040, 32'hFFFF_FFFF, 4'h0, 32'h5A5A_A5A5, -1, 0);
    set_row(4, "zero_data", 32'h0000_0044, 32'h0000_0000, 4'hF, 32'hFFFF_FFFF, -1, 0);
    set_row(5, "flip_data_bit", 32'h0000_3000, 32'h0102_0304, 4'hC, 32'h8765_4321, 10, 0);
    set_row(6, "flip_parity_bit", 32'h0000_3004, 32'h7777_0000, 4'hF, 32'h0000_FFFF, 7, 0);
    set_row(7, "memory_full", 32'hFFFF_FFFC, 32'h1357_9BDF, 4'h9, 32'h2468_ACE0, -1, 4);
    for (int i = 8; i < NROWS; i++)
    begin
      foreach (r[k])
        r[k] = $urandom;
      set_row(i, (i == 8) ? "random_flip" : "random_clean", r[0], r[1], 4'(r[2]), r[3],
              (i == 8) ? int'(r[4] % 38) : -1, int'(r[5] % 4));
    end
  endtask

  task automatic run_row(input int i);
    wr_cmd_t req;
    cw_t     rd_cw;
    data_t   exp_merge;
    logic    exp_err;
    int      lat;
    int      rd_at;
    int      rd_cnt;
    string   nm;
    nm  = row_name[i];
    req = '{addr: row_addr[i], data: row_data[i], strb: row_strb[i]};
    rd_cw = ref_encode(row_old[i]);
    if (row_flip[i] >= 0)
      rd_cw[row_flip[i]] = ~rd_cw[row_flip[i]];
    exp_merge = ref_merge(req.data, ref_extract(rd_cw), req.strb);
    exp_err   = (row_flip[i] >= 0);
    @(posedge e_clk);
    #2;
    douta = rd_cw;
    // request pulsed while full must be dropped
    if (row_hold[i] > 0)
    begin
      mem_full = 1'b1;
      cmd      = req;
      wr_req   = 1'b1;
      repeat (row_hold[i])
      begin
        @(negedge e_clk);
        check_val(nm, "en_ready/mem.ena while full", 64'(0), 64'({en_ready, mem.ena}));
        @(posedge e_clk);
        #2;
        wr_req = 1'b0;
      end
      mem_full = 1'b0;
    end
    @(negedge e_clk);
    while (en_ready !== 1'b1)
    begin
      check_val(nm, "mem.ena before accept", 64'(0), 64'(mem.ena));
      @(negedge e_clk);
    end
    check_val(nm, "mem.ena in idle", 64'(0), 64'(mem.ena));
    @(posedge e_clk);
    #2;
    cmd    = req;
    wr_req = 1'b1;
    @(negedge e_clk);
    check_val(nm, "en_ready at request", 64'(1), 64'(en_ready));
    @(posedge e_clk);
    #2;
    wr_req = 1'b0;
    // the latched copy has to carry the operation
    cmd    = ~req;
    lat    = 0;
    rd_at  = 0;
    rd_cnt = 0;
    do
    begin
      @(negedge e_clk);
      lat++;
      check_val(nm, "en_ready while busy", 64'(0), 64'(en_ready));
      if (mem.ena && !mem.wea)
      begin
        rd_cnt++;
        rd_at = lat;
        check_val(nm, "read mem.addr", 64'(req.addr), 64'(mem.addr));
      end
    end
    while (bvalid !== 1'b1);
    check_val(nm, "read strobes", 64'(1), 64'(rd_cnt));
    check_val(nm, "read latency", 64'(RD_LAT), 64'(rd_at));
    check_val(nm, "write latency", 64'(WR_LAT), 64'(lat));
    check_val(nm, "write mem.ena/wea", 64'(2'b11), 64'({mem.ena, mem.wea}));
    check_val(nm, "write mem.addr", 64'(req.addr), 64'(mem.addr));
    check_val(nm, "mem.wdata", 64'(ref_encode(exp_merge)), 64'(mem.wdata));
    check_val(nm, "err_detected", 64'(exp_err), 64'(err_detected));
    @(negedge e_clk);
    check_val(nm, "bvalid/mem.ena after write", 64'(0), 64'({bvalid, mem.ena}));
    check_val(nm, "en_ready back in idle", 64'(1), 64'(en_ready));
    check_val(nm, "err_detected held", 64'(exp_err), 64'(err_detected));
  endtask

  initial
  begin
    int unsigned seed_ret;
    wr_req   = 1'b0;
    cmd      = '0;
    mem_full = 1'b0;
    douta    = '0;
    seed_ret = $urandom(RAND_SEED);
    load_table();
    @(posedge e_clk);
    @(negedge e_clk);
    check_val("reset", "ready/ena/wea/bvalid/err", 64'(0),
              64'({en_ready, mem.ena, mem.wea, bvalid, err_detected}));
    wait (e_rst == 1'b0);
    for (int i = 0; i < NROWS; i++)
      run_row(i);
    $display("Test OK");
    $finish;
  end

endmodule

// ==== verif/tb_clkgen.sv ====
module tb_clkgen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 3
) (
  output logic e_clk,
  output logic e_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    e_clk = 1'b0;
    forever #(PERIOD_NS / 2) e_clk = ~e_clk;
  end

  // release just after an edge, like the other inputs
  initial
  begin
    e_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge e_clk);
    #2 e_rst = 1'b0;
  end

endmodule
